// ==== design/tl_pkg.sv ====
`default_nettype none

package tl_pkg;

  // Bus geometry of the single-beat TileLink-UL link
  parameter int TL_DW  = 32;        // Data bus width in bits
  parameter int TL_AW  = 32;        // Byte address width
  parameter int TL_DBW = TL_DW / 8; // Bytes per bus word
  parameter int TL_SZW = 2;         // Width of the log2 size field
  parameter int TL_AIW = 8;         // Source identifier width

  typedef logic [TL_DW-1:0]  tl_data_t;
  typedef logic [TL_DBW-1:0] tl_mask_t;
  typedef logic [TL_AW-1:0]  tl_addr_t;
  typedef logic [TL_SZW-1:0] tl_size_t;
  typedef logic [TL_AIW-1:0] tl_source_t;
  typedef logic [2:0]        tl_opcode_t;

  // A channel opcodes handled by the adapter
  localparam tl_opcode_t PutFullData    = 3'h0;
  localparam tl_opcode_t PutPartialData = 3'h1;
  localparam tl_opcode_t Get            = 3'h4;

  // D channel opcodes
  localparam tl_opcode_t AccessAck     = 3'h0;
  localparam tl_opcode_t AccessAckData = 3'h1;

  // Host to device, A channel request plus D channel ready
  typedef struct packed {
    logic       a_valid;
    tl_opcode_t a_opcode;
    tl_size_t   a_size;
    tl_source_t a_source;
    tl_addr_t   a_address;
    tl_mask_t   a_mask;
    tl_data_t   a_data;
    logic       d_ready;
  } tl_h2d_t;

  // Device to host, D channel response plus A channel ready
  typedef struct packed {
    logic       d_valid;
    tl_opcode_t d_opcode;
    tl_size_t   d_size;
    tl_source_t d_source;
    tl_data_t   d_data;
    logic       d_error;
    logic       a_ready;
  } tl_d2h_t;

endpackage

`default_nettype wire

// ==== design/sram_adapter_pkg.sv ====
`default_nettype none

package sram_adapter_pkg;

  // One record per accepted A request, kept until its D response leaves
  typedef struct packed {
    logic              is_read; // Response carries data (Get)
    logic              error;   // Request was rejected and never reached the SRAM
    tl_pkg::tl_size_t   size;    // Echoed on d_size
    tl_pkg::tl_source_t source;  // Echoed on d_source
  } req_rec_t;

  // One word returned by the SRAM, already masked to the requested bytes
  typedef struct packed {
    tl_pkg::tl_data_t data;
    logic             error; // Uncorrectable error seen on the read
  } rsp_rec_t;

  // FIFO widths for the two record types
  localparam int ReqRecW = $bits(req_rec_t);
  localparam int RspRecW = $bits(rsp_rec_t);

endpackage

`default_nettype wire

// ==== design/sync_fifo.sv ====
`default_nettype none
`timescale 1ns/10ps

module sync_fifo #(
  parameter int Width = 8,
  parameter int Depth = 2,
  parameter bit Pass  = 1'b0 // Empty FIFO forwards write data in the same cycle
) (
  input  wire logic             clk_i,
  input  wire logic             rst_n_i,
  input  wire logic             wvalid_i,
  input  wire logic [Width-1:0] wdata_i,
  output logic                  wready_o,
  output logic                  rvalid_o,
  input  wire logic             rready_i,
  output logic      [Width-1:0] rdata_o
);

  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW = $clog2(Depth + 1);

  typedef logic [PtrW-1:0] ptr_t;
  typedef logic [CntW-1:0] cnt_t;

  logic [Width-1:0] mem [Depth]; // Storage, no reset needed on payload
  ptr_t wptr, rptr;
  cnt_t count;
  logic empty, full;
  logic pass_thru; // Write goes straight to the read side
  logic wr_en, rd_en;

  assign empty = (count == '0);
  assign full  = (count == cnt_t'(Depth));

  assign pass_thru = Pass && empty && wvalid_i;
  assign wready_o  = ~full;
  assign rvalid_o  = ~empty | pass_thru;
  assign rdata_o   = (Pass && empty) ? wdata_i : mem[rptr];

  // A passed-through word that is consumed at once is never stored
  assign wr_en = wvalid_i & wready_o & ~(pass_thru & rready_i);
  assign rd_en = ~empty & rready_i;

  always_ff @(posedge clk_i) begin
    if (wr_en) mem[wptr] <= wdata_i;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (wr_en) wptr <= (wptr == ptr_t'(Depth - 1)) ? '0 : wptr + 1'b1; // Wrap at Depth
      if (rd_en) rptr <= (rptr == ptr_t'(Depth - 1)) ? '0 : rptr + 1'b1;
      if (wr_en && !rd_en) count <= count + 1'b1;
      else if (!wr_en && rd_en) count <= count - 1'b1;
    end
  end

  // Producers only push when there is room, the adapter relies on this for in-order tracking
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wvalid_i |-> wready_o)
    else $error("sync_fifo written while full");

endmodule

`default_nettype wire

// ==== design/tl_req_decoder.sv ====
`default_nettype none
`timescale 1ns/10ps

module tl_req_decoder #(
  parameter int SramAw     = 10,
  parameter bit ByteAccess = 1'b1, // Partial writes allowed
  parameter bit ErrOnWrite = 1'b0, // Every write is rejected
  parameter bit ErrOnRead  = 1'b0  // Every Get is rejected
) (
  input  wire logic                      clk_i,
  input  wire logic                      rst_n_i,
  input  wire tl_pkg::tl_h2d_t           tl_i,
  input  wire logic                      req_ready_i,  // Request FIFO has room
  input  wire logic                      mask_ready_i, // Read-mask FIFO has room
  input  wire logic                      gnt_i,
  output logic                           a_ready_o,
  output logic                           req_o,
  output logic                           we_o,
  output logic [SramAw-1:0]              addr_o,
  output tl_pkg::tl_data_t               wdata_o,
  output tl_pkg::tl_data_t               wmask_o,
  output logic                           req_push_o,
  output sram_adapter_pkg::req_rec_t     req_rec_o,
  output logic                           mask_push_o,
  output tl_pkg::tl_mask_t               mask_o
);

  logic is_get, is_put;
  logic op_err, size_err, align_err;
  logic wr_attr_err, wr_vld_err, rd_vld_err;
  logic error;
  logic room; // Both tracking FIFOs can take an entry

  assign is_get = (tl_i.a_opcode == tl_pkg::Get);
  assign is_put = (tl_i.a_opcode == tl_pkg::PutFullData) ||
                  (tl_i.a_opcode == tl_pkg::PutPartialData);

  // Local protocol checks on opcode, size and alignment
  assign op_err   = ~(is_get | is_put);
  assign size_err = (tl_i.a_size > 2'd2); // Nothing wider than one bus word

  always_comb begin
    unique case (tl_i.a_size)
      2'd1:    align_err = tl_i.a_address[0];
      2'd2:    align_err = |tl_i.a_address[1:0];
      default: align_err = 1'b0; // Byte access is always aligned
    endcase
  end

  // Without byte access only full-word writes are legal
  assign wr_attr_err = !ByteAccess && is_put && ((tl_i.a_mask != '1) || (tl_i.a_size != 2'd2));
  assign wr_vld_err  = ErrOnWrite && is_put;
  assign rd_vld_err  = ErrOnRead && is_get;

  assign error = op_err | size_err | align_err | wr_attr_err | wr_vld_err | rd_vld_err;
  assign room  = req_ready_i & mask_ready_i;

  // A rejected request needs no grant since it never goes to the SRAM
  assign a_ready_o = (gnt_i | error) & room;
  assign req_o     = tl_i.a_valid & ~error & room;
  assign we_o      = tl_i.a_valid & is_put;
  assign addr_o    = tl_i.a_address[2 +: SramAw]; // Word address with the byte offset dropped

  // Byte mask widened to a bit mask and data outside it forced to zero
  always_comb begin
    wmask_o = '0;
    for (int i = 0; i < tl_pkg::TL_DBW; i++) begin
      wmask_o[8*i +: 8] = {8{tl_i.a_mask[i] & we_o}};
    end
  end
  assign wdata_o = tl_i.a_data & wmask_o;

  // Every accepted request gets a record including rejected ones
  assign req_push_o       = tl_i.a_valid & a_ready_o;
  assign req_rec_o.is_read = is_get;
  assign req_rec_o.error   = error;
  assign req_rec_o.size    = tl_i.a_size;
  assign req_rec_o.source  = tl_i.a_source;

  // Granted reads leave their byte mask for the returning data
  assign mask_push_o = req_o & gnt_i & is_get;
  assign mask_o      = tl_i.a_mask;

  // A grant only ever answers a request that the decoder raised
  a_gnt_has_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    gnt_i |-> req_o)
    else $error("SRAM grant without a pending request");

endmodule

`default_nettype wire

// ==== design/sram_read_return.sv ====
`default_nettype none
`timescale 1ns/10ps

module sram_read_return #(
  parameter int Outstanding = 2
) (
  input  wire logic                   clk_i,
  input  wire logic                   rst_n_i,
  input  wire logic                   mask_push_i, // Granted read
  input  wire tl_pkg::tl_mask_t       mask_i,
  input  wire tl_pkg::tl_data_t       rdata_i,
  input  wire logic                   rvalid_i,
  input  wire logic [1:0]             rerror_i,    // [1] uncorrectable, [0] correctable
  input  wire logic                   rsp_pop_i,
  output logic                        mask_ready_o,
  output logic                        rsp_valid_o,
  output sram_adapter_pkg::rsp_rec_t  rsp_o
);

  tl_pkg::tl_mask_t           mask_head; // Mask of the oldest read still in flight
  logic                       mask_valid;
  tl_pkg::tl_data_t           rmask;
  sram_adapter_pkg::rsp_rec_t rsp_in;

  // Masks wait here until the SRAM answers, one entry per read
  sync_fifo #(
    .Width (tl_pkg::TL_DBW),
    .Depth (Outstanding),
    .Pass  (1'b0)
  ) u_mask_fifo (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .wvalid_i (mask_push_i),
    .wdata_i  (mask_i),
    .wready_o (mask_ready_o),
    .rvalid_o (mask_valid),
    .rready_i (rvalid_i),    // Read data retires the oldest mask
    .rdata_o  (mask_head)
  );

  always_comb begin
    rmask = '0;
    for (int i = 0; i < tl_pkg::TL_DBW; i++) begin
      rmask[8*i +: 8] = {8{mask_head[i]}};
    end
  end

  // Only the uncorrectable flag is reported back to the host
  assign rsp_in.data  = rdata_i & rmask;
  assign rsp_in.error = rerror_i[1];

  // Pass-through lets a read answer on the D channel in the rvalid_i cycle
  sync_fifo #(
    .Width (sram_adapter_pkg::RspRecW),
    .Depth (Outstanding),
    .Pass  (1'b1)
  ) u_rsp_fifo (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .wvalid_i (rvalid_i),
    .wdata_i  (rsp_in),
    .wready_o (),            // The request FIFO depth bounds what can arrive here
    .rvalid_o (rsp_valid_o),
    .rready_i (rsp_pop_i),
    .rdata_o  (rsp_o)
  );

  // SRAM only returns data for reads that the decoder handed over
  a_rvalid_has_mask: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_i |-> mask_valid)
    else $error("Read data returned with no read in flight");

endmodule

`default_nettype wire

// ==== design/tl_rsp_builder.sv ====
`default_nettype none
`timescale 1ns/10ps

module tl_rsp_builder #(
  parameter int Outstanding = 2
) (
  input  wire logic                       clk_i,
  input  wire logic                       rst_n_i,
  input  wire logic                       req_push_i,
  input  wire sram_adapter_pkg::req_rec_t req_rec_i,
  input  wire logic                       rsp_valid_i, // Read word waiting
  input  wire sram_adapter_pkg::rsp_rec_t rsp_i,
  input  wire logic                       d_ready_i,
  output logic                            req_ready_o,
  output logic                            rsp_pop_o,
  output tl_pkg::tl_d2h_t                 d_o
);

  sram_adapter_pkg::req_rec_t head; // Oldest request not yet answered
  logic head_valid;
  logic needs_data;                 // Head waits on the response FIFO
  logic d_valid;
  logic head_pop;

  // Records keep the D channel in acceptance order
  sync_fifo #(
    .Width (sram_adapter_pkg::ReqRecW),
    .Depth (Outstanding),
    .Pass  (1'b0)
  ) u_req_fifo (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .wvalid_i (req_push_i),
    .wdata_i  (req_rec_i),
    .wready_o (req_ready_o),
    .rvalid_o (head_valid),
    .rready_i (head_pop),
    .rdata_o  (head)
  );

  assign needs_data = head.is_read & ~head.error;

  // Writes and rejected requests answer at once, clean reads wait for data
  assign d_valid   = head_valid & (~needs_data | rsp_valid_i);
  assign head_pop  = d_valid & d_ready_i;
  assign rsp_pop_o = head_pop & needs_data;

  always_comb begin
    d_o          = '0;
    d_o.d_valid  = d_valid;
    d_o.d_opcode = head.is_read ? tl_pkg::AccessAckData : tl_pkg::AccessAck;
    d_o.d_size   = head.size;
    d_o.d_source = head.source;
    d_o.d_data   = (d_valid && needs_data) ? rsp_i.data : '0; // Zero for writes and errors
    d_o.d_error  = d_valid & (head.error | (needs_data & rsp_i.error));
    // a_ready stays zero here, the top level supplies it
  end

  // Read data only shows up while a clean read sits at the head
  a_rsp_matches_head: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_i |-> (head_valid && needs_data))
    else $error("Read data arrived while the head record is not a clean read");

endmodule

`default_nettype wire

// ==== design/tl_sram_adapter.sv ====
`default_nettype none
`timescale 1ns/10ps

module tl_sram_adapter #(
  parameter int SramAw      = 10,
  parameter int Outstanding = 2,
  parameter bit ByteAccess  = 1'b1,
  parameter bit ErrOnWrite  = 1'b0,
  parameter bit ErrOnRead   = 1'b0
) (
  input  wire logic              clk_i,
  input  wire logic              rst_n_i,
  input  wire tl_pkg::tl_h2d_t   tl_i,
  output tl_pkg::tl_d2h_t        tl_o,
  output logic                   req_o,
  input  wire logic              gnt_i,
  output logic                   we_o,
  output logic [SramAw-1:0]      addr_o,
  output tl_pkg::tl_data_t       wdata_o,
  output tl_pkg::tl_data_t       wmask_o,
  input  wire tl_pkg::tl_data_t  rdata_i,
  input  wire logic              rvalid_i,
  input  wire logic [1:0]        rerror_i
);

  logic                       a_ready;
  logic                       req_ready, mask_ready;
  logic                       req_push, mask_push;
  sram_adapter_pkg::req_rec_t req_rec;
  tl_pkg::tl_mask_t           mask;
  logic                       rsp_valid, rsp_pop;
  sram_adapter_pkg::rsp_rec_t rsp;
  tl_pkg::tl_d2h_t            d_rsp; // D channel from the builder, a_ready still zero

  tl_req_decoder #(
    .SramAw     (SramAw),
    .ByteAccess (ByteAccess),
    .ErrOnWrite (ErrOnWrite),
    .ErrOnRead  (ErrOnRead)
  ) u_decoder (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .tl_i         (tl_i),
    .req_ready_i  (req_ready),
    .mask_ready_i (mask_ready),
    .gnt_i        (gnt_i),
    .a_ready_o    (a_ready),
    .req_o        (req_o),
    .we_o         (we_o),
    .addr_o       (addr_o),
    .wdata_o      (wdata_o),
    .wmask_o      (wmask_o),
    .req_push_o   (req_push),
    .req_rec_o    (req_rec),
    .mask_push_o  (mask_push),
    .mask_o       (mask)
  );

  sram_read_return #(
    .Outstanding (Outstanding)
  ) u_read_return (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .mask_push_i  (mask_push),
    .mask_i       (mask),
    .rdata_i      (rdata_i),
    .rvalid_i     (rvalid_i),
    .rerror_i     (rerror_i),
    .rsp_pop_i    (rsp_pop),
    .mask_ready_o (mask_ready),
    .rsp_valid_o  (rsp_valid),
    .rsp_o        (rsp)
  );

  tl_rsp_builder #(
    .Outstanding (Outstanding)
  ) u_builder (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_push_i  (req_push),
    .req_rec_i   (req_rec),
    .rsp_valid_i (rsp_valid),
    .rsp_i       (rsp),
    .d_ready_i   (tl_i.d_ready),
    .req_ready_o (req_ready),
    .rsp_pop_o   (rsp_pop),
    .d_o         (d_rsp)
  );

  // Merge the A channel ready into the builder's response
  always_comb begin
    tl_o         = d_rsp;
    tl_o.a_ready = a_ready;
  end

endmodule

`default_nettype wire

// ==== verification/sram_model.sv ====
`default_nettype none
`timescale 1ns/10ps

module sram_model #(
  parameter int Aw = 10
) (
  input  wire logic          clk_i,
  input  wire logic          rst_n_i,
  input  wire logic          gnt_en_i, // Grant is allowed in this cycle
  input  wire logic          inject_i, // Read granted in this cycle comes back uncorrectable
  input  wire logic          req_i,
  output logic               gnt_o,
  input  wire logic          we_i,
  input  wire logic [Aw-1:0] addr_i,
  input  wire logic [31:0]   wdata_i,
  input  wire logic [31:0]   wmask_i,
  output logic [31:0]        rdata_o,
  output logic               rvalid_o,
  output logic [1:0]         rerror_o
);

  logic [31:0] mem [2**Aw];
  logic        rd_fire; // Read granted this cycle

  // Every word starts different, the pattern mixes all address bits
  initial begin
    for (int i = 0; i < 2**Aw; i++) begin
      mem[i] = (i + 1) * 32'h9e37_79b1;
    end
  end

  assign gnt_o   = req_i & gnt_en_i;
  assign rd_fire = gnt_o & ~we_i;

  always @(posedge clk_i) begin
    if (gnt_o && we_i) begin
      mem[addr_i] <= (mem[addr_i] & ~wmask_i) | (wdata_i & wmask_i); // Bit-masked write
    end
  end

  // Read data returns exactly one cycle after the grant
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
      rerror_o <= '0;
    end else begin
      rvalid_o    <= rd_fire;
      rdata_o     <= rd_fire ? mem[addr_i] : '0;
      rerror_o[1] <= rd_fire & inject_i;
      rerror_o[0] <= rd_fire & addr_i[0]; // Correctable flag on odd words, the adapter ignores it
    end
  end

endmodule

`default_nettype wire

// ==== verification/tb_tl_sram_adapter.sv ====
`default_nettype none
`timescale 1ns/10ps

module tb_tl_sram_adapter;

  localparam int          SramAw  = 10;
  localparam int          Timeout = 200;           // Cycles that any single wait may take
  localparam logic [31:0] Seed    = 32'hf4af27fa;
  localparam tl_pkg::tl_opcode_t OpArith = 3'h2;  // ArithmeticData which the adapter does not handle

  // One accepted A request as seen on the bus
  typedef struct packed {
    tl_pkg::tl_opcode_t opcode;
    tl_pkg::tl_size_t   size;
    tl_pkg::tl_source_t source;
    tl_pkg::tl_addr_t   address;
    tl_pkg::tl_mask_t   mask;
    tl_pkg::tl_data_t   data;
    logic               inject; // SRAM flagged this read as uncorrectable
  } req_t;

  // Expected D response fields
  typedef struct packed {
    tl_pkg::tl_opcode_t opcode;
    tl_pkg::tl_size_t   size;
    tl_pkg::tl_source_t source;
    tl_pkg::tl_data_t   data;
    logic               error;
  } rsp_t;

  logic              clk_i = 1'b0;
  logic              rst_n_i;
  tl_pkg::tl_h2d_t   host_a; // A channel fields from the stimulus
  logic              d_ready;
  tl_pkg::tl_h2d_t   tl_h2d;
  tl_pkg::tl_d2h_t   tl_d2h;
  logic              req;
  logic              gnt;
  logic              gnt_en;
  logic              inject;
  logic              we;
  logic              rvalid;
  logic [SramAw-1:0] addr;
  tl_pkg::tl_data_t  wdata;
  tl_pkg::tl_data_t  wmask;
  tl_pkg::tl_data_t  rdata;
  logic [1:0]        rerror;

  logic [31:0]        shadow [2**SramAw]; // Expected SRAM contents
  req_t               pending [$];        // Accepted requests still waiting for D
  logic [31:0]        stim_state = Seed;
  logic [31:0]        stall_state = ~Seed; // Own sequence for the stall process
  tl_pkg::tl_source_t next_source = '0;
  int                 errors = 0;
  int                 checks = 0;
  int                 tests_run = 0;
  int                 tests_failed = 0;
  int                 test_base = 0;
  string              test_name;
  logic               timed_out = 1'b0;
  logic               stalls_on = 1'b0;
  logic               held = 1'b0;         // Last cycle showed d_valid without d_ready
  logic [63:0]        held_d;

  always #2 clk_i = ~clk_i; // 4 ns period

  always_comb begin
    tl_h2d         = host_a;
    tl_h2d.d_ready = d_ready;
  end

  tl_sram_adapter #(
    .SramAw      (SramAw),
    .Outstanding (2),
    .ByteAccess  (1'b1),
    .ErrOnWrite  (1'b0),
    .ErrOnRead   (1'b0)
  ) uut (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .tl_i     (tl_h2d),
    .tl_o     (tl_d2h),
    .req_o    (req),
    .gnt_i    (gnt),
    .we_o     (we),
    .addr_o   (addr),
    .wdata_o  (wdata),
    .wmask_o  (wmask),
    .rdata_i  (rdata),
    .rvalid_i (rvalid),
    .rerror_i (rerror)
  );

  sram_model #(
    .Aw (SramAw)
  ) u_sram (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .gnt_en_i (gnt_en),
    .inject_i (inject),
    .req_i    (req),
    .gnt_o    (gnt),
    .we_i     (we),
    .addr_i   (addr),
    .wdata_i  (wdata),
    .wmask_i  (wmask),
    .rdata_o  (rdata),
    .rvalid_o (rvalid),
    .rerror_o (rerror)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    stim_state = xorshift32(stim_state);
    return stim_state;
  endfunction

  function automatic tl_pkg::tl_addr_t rand_word_addr();
    logic [31:0] r;
    r = next_rand();
    return {20'h0, r[9:0], 2'b00}; // Word aligned address inside the SRAM
  endfunction

  // Power-up contents of the SRAM model
  function automatic logic [31:0] fill_word(input int a);
    return (a + 1) * 32'h9e37_79b1;
  endfunction

  function automatic logic [31:0] byte_bits(input tl_pkg::tl_mask_t m);
    logic [31:0] b;
    for (int i = 0; i < 4; i++) begin
      b[8*i +: 8] = {8{m[i]}};
    end
    return b;
  endfunction

  function automatic logic request_is_bad(input req_t r);
    logic misaligned;
    logic known_op;
    misaligned = (r.size == 2'd1 && r.address[0]) || (r.size == 2'd2 && r.address[1:0] != 2'b00);
    known_op   = (r.opcode == tl_pkg::Get) || (r.opcode == tl_pkg::PutFullData) ||
                 (r.opcode == tl_pkg::PutPartialData);
    return !known_op || (r.size == 2'd3) || misaligned;
  endfunction

  // Applies one request to the shadow memory and returns its response
  function automatic rsp_t expected_response(input req_t r);
    rsp_t              e;
    logic [SramAw-1:0] w;
    logic [31:0]       bits;
    w        = r.address[2 +: SramAw];
    bits     = byte_bits(r.mask);
    e.opcode = (r.opcode == tl_pkg::Get) ? tl_pkg::AccessAckData : tl_pkg::AccessAck;
    e.size   = r.size;
    e.source = r.source;
    e.data   = '0;
    e.error  = request_is_bad(r); // Rejected requests never touch memory
    if (!e.error && r.opcode == tl_pkg::Get) begin
      e.data  = shadow[w] & bits; // A flagged read still carries its masked word
      e.error = r.inject;
    end else if (!e.error) begin
      shadow[w] = (shadow[w] & ~bits) | (r.data & bits);
    end
    return e;
  endfunction

  function automatic logic [63:0] d_fields(input tl_pkg::tl_d2h_t d);
    return {d.d_valid, d.d_opcode, d.d_size, d.d_source, d.d_data, d.d_error};
  endfunction

  task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] time %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // Both channels are sampled mid-cycle where every input has settled
  always @(negedge clk_i) begin : watch_channels
    req_t r;
    rsp_t e;
    if (rst_n_i) begin
      if (held) check_value("held D response", d_fields(tl_d2h), held_d);
      if (tl_d2h.d_valid && d_ready) begin
        if (pending.size() == 0) begin
          errors++;
          $display("Time %0d ns: D response arrived with no request outstanding", $time);
        end else begin
          r = pending.pop_front();
          e = expected_response(r);
          check_value("d_opcode", tl_d2h.d_opcode, e.opcode);
          check_value("d_size", tl_d2h.d_size, e.size);
          check_value("d_source", tl_d2h.d_source, e.source);
          check_value("d_data", tl_d2h.d_data, e.data);
          check_value("d_error", tl_d2h.d_error, e.error);
        end
      end
      held   = tl_d2h.d_valid && !d_ready;
      held_d = d_fields(tl_d2h);
      if (host_a.a_valid && tl_d2h.a_ready) begin
        r = {host_a.a_opcode, host_a.a_size, host_a.a_source, host_a.a_address,
             host_a.a_mask, host_a.a_data, inject};
        pending.push_back(r);
      end
    end
  end

  // Random grant and D stalls that hold a response back only behind a clean read
  always @(posedge clk_i) begin : drive_stalls
    logic stall_now;
    logic head_read;
    stall_now = stalls_on;
    #1;
    stall_state = xorshift32(stall_state);
    head_read   = (pending.size() != 0) && (pending[0].opcode == tl_pkg::Get) &&
                  !request_is_bad(pending[0]);
    gnt_en  = !stall_now || (stall_state[1:0] != 2'b00);
    d_ready = !stall_now || !head_read || stall_state[4];
  end

  // Presents one A request and holds it until the adapter takes it
  task automatic issue(input tl_pkg::tl_opcode_t op, input tl_pkg::tl_size_t size,
                       input tl_pkg::tl_addr_t address, input tl_pkg::tl_mask_t mask,
                       input tl_pkg::tl_data_t data, input logic flag_read);
    int   n;
    logic taken;
    n     = 0;
    taken = 1'b0;
    host_a.a_valid   = 1'b1;
    host_a.a_opcode  = op;
    host_a.a_size    = size;
    host_a.a_source  = next_source;
    host_a.a_address = address;
    host_a.a_mask    = mask;
    host_a.a_data    = data;
    inject           = flag_read;
    next_source++;
    while (!taken && !timed_out) begin
      @(negedge clk_i);
      taken = tl_d2h.a_ready;
      @(posedge clk_i);
      #1;
      n++;
      if (!taken && n >= Timeout) begin
        $display("Timeout: request from source %0d was not accepted within %0d cycles",
                 host_a.a_source, Timeout);
        timed_out = 1'b1;
      end
    end
    host_a = '0;
    inject = 1'b0;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (!timed_out && pending.size() != 0) begin
      @(negedge clk_i);
      #1;
      n++;
      if (n >= Timeout && pending.size() != 0) begin
        $display("Timeout: %0d responses still outstanding after %0d cycles",
                 pending.size(), Timeout);
        timed_out = 1'b1;
      end
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_base = errors;
  endtask

  task automatic end_test();
    wait_idle();
    tests_run++;
    if (errors != test_base || timed_out) begin
      tests_failed++;
      $display("Test %0d %s: failed, %0d errors", tests_run, test_name, errors - test_base);
    end else begin
      $display("Test %0d %s: passed", tests_run, test_name);
    end
  endtask

  task automatic write_then_read();
    tl_pkg::tl_addr_t a;
    begin_test("full write then read");
    repeat (4) begin
      a = rand_word_addr();
      issue(tl_pkg::PutFullData, 2'd2, a, 4'hf, next_rand(), 1'b0);
      issue(tl_pkg::Get, 2'd2, a, 4'hf, '0, 1'b0);
    end
    end_test();
  endtask

  task automatic partial_write_merge();
    tl_pkg::tl_addr_t a;
    logic [31:0]      r;
    begin_test("partial write merge");
    repeat (6) begin
      a = rand_word_addr();
      r = next_rand();
      issue(tl_pkg::PutPartialData, 2'd2, a, r[3:0], next_rand(), 1'b0);
      issue(tl_pkg::Get, 2'd2, a, 4'hf, '0, 1'b0); // Shows the merged word
    end
    end_test();
  endtask

  task automatic partial_read_masking();
    tl_pkg::tl_addr_t a;
    logic [31:0]      r;
    begin_test("partial read masking");
    repeat (4) begin
      a = rand_word_addr();
      r = next_rand();
      issue(tl_pkg::Get, 2'd0, a + r[1:0], 4'b0001 << r[1:0], '0, 1'b0);
      issue(tl_pkg::Get, 2'd1, a + {r[2], 1'b0}, r[2] ? 4'hc : 4'h3, '0, 1'b0);
    end
    end_test();
  endtask

  task automatic rejected_requests();
    tl_pkg::tl_addr_t a;
    begin_test("rejected requests");
    a = rand_word_addr();
    issue(tl_pkg::PutFullData, 2'd2, a, 4'hf, next_rand(), 1'b0);
    issue(OpArith, 2'd2, a, 4'hf, next_rand(), 1'b0);
    issue(tl_pkg::PutFullData, 2'd3, a, 4'hf, next_rand(), 1'b0);
    issue(tl_pkg::PutFullData, 2'd2, a + 2, 4'hf, next_rand(), 1'b0);
    issue(tl_pkg::Get, 2'd1, a + 1, 4'h3, '0, 1'b0);
    issue(tl_pkg::Get, 2'd2, a, 4'hf, '0, 1'b0); // Word must still hold the first write
    end_test();
  endtask

  task automatic mixed_stream();
    tl_pkg::tl_opcode_t op;
    tl_pkg::tl_size_t   size;
    tl_pkg::tl_mask_t   mask;
    logic [31:0]        r;
    begin_test("mixed stream under stalls");
    stalls_on = 1'b1;
    for (int i = 0; i < 64; i++) begin
      r    = next_rand();
      op   = (r[1:0] == 2'd2) ? tl_pkg::PutFullData :
             (r[1:0] == 2'd3) ? tl_pkg::PutPartialData : tl_pkg::Get;
      size = (r[13:12] == 2'd3) ? 2'd2 : r[13:12];
      mask = (op == tl_pkg::PutPartialData) ? r[11:8] : 4'hf;
      // Eight words only, so reads keep hitting recent writes
      issue(op, size, 32'h100 + {r[4:2], 2'b00}, mask, next_rand(), 1'b0);
    end
    end_test();
    stalls_on = 1'b0;
  endtask

  task automatic read_error_report();
    tl_pkg::tl_addr_t a;
    begin_test("uncorrectable read error");
    a = rand_word_addr();
    issue(tl_pkg::PutFullData, 2'd2, a, 4'hf, next_rand(), 1'b0);
    issue(tl_pkg::Get, 2'd2, a, 4'hf, '0, 1'b1);
    issue(tl_pkg::Get, 2'd2, a, 4'hf, '0, 1'b0);
    issue(tl_pkg::Get, 2'd2, a ^ 32'h40, 4'hf, '0, 1'b0);
    end_test();
  endtask

  initial begin : run_all
    for (int i = 0; i < 2**SramAw; i++) begin
      shadow[i] = fill_word(i);
    end
    rst_n_i = 1'b0;
    host_a  = '0;
    d_ready = 1'b1;
    gnt_en  = 1'b1;
    inject  = 1'b0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    check_value("d_valid after reset", tl_d2h.d_valid, 1'b0);
    check_value("req_o after reset", req, 1'b0);
    if (!timed_out) write_then_read();
    if (!timed_out) partial_write_merge();
    if (!timed_out) partial_read_masking();
    if (!timed_out) rejected_requests();
    if (!timed_out) mixed_stream();
    if (!timed_out) read_error_report();
    $display("Summary: %0d tests run, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
design/tl_pkg.sv
design/sram_adapter_pkg.sv
design/sync_fifo.sv
design/tl_req_decoder.sv
design/sram_read_return.sv
design/tl_rsp_builder.sv
design/tl_sram_adapter.sv
verification/sram_model.sv
verification/tb_tl_sram_adapter.sv
